// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tbExPipeline
FILELIST = sources.f
BUILD    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf $(BUILD)

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  pipePkg::opcodeT               op,
    input  logic [pipePkg::dataWidth-1:0] a,
    input  logic [pipePkg::dataWidth-1:0] b,
    input  logic [pipePkg::immWidth-1:0]  imm,
    output logic [pipePkg::dataWidth-1:0] result
);

    logic [pipePkg::dataWidth-1:0] immExt;
    logic [4:0]                    shamt;
    logic                          lessThan;

    // Sign extension of the 16-bit field
    assign immExt = {{(pipePkg::dataWidth - pipePkg::immWidth){imm[pipePkg::immWidth-1]}},
                     imm};

    // Shift amount lives in the low immediate bits
    assign shamt = imm[4:0];

    // Two's complement compare
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            pipePkg::opAdd: result = a + b;
            pipePkg::opSub: result = a - b;
            pipePkg::opAnd: result = a & b;
            pipePkg::opOr:  result = a | b;
            pipePkg::opSlt: result = {{(pipePkg::dataWidth - 1){1'b0}}, lessThan};
            pipePkg::opSll: result = b << shamt;
            // Addi result and load/store address share the adder
            pipePkg::opAddi,
            pipePkg::opLw,
            pipePkg::opSw:  result = a + immExt;
            // Nop
            default:        result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== exForwarding.sv ====
`timescale 1ns/1ps
`default_nettype none

module exForwarding (
    // Instruction now in EX
    input  pipePkg::opcodeT                  idExOp,
    input  logic [pipePkg::regAddrWidth-1:0] idExRs,
    input  logic [pipePkg::regAddrWidth-1:0] idExRt,
    // One stage ahead
    input  logic [pipePkg::regAddrWidth-1:0] exMemDest,
    input  logic                             exMemRegWrite,
    input  logic                             exMemMemRead,
    // Two stages ahead
    input  logic [pipePkg::regAddrWidth-1:0] memWbDest,
    input  logic                             memWbRegWrite,
    // Selects back to exStage
    output pipePkg::fwdSelT                  fwdA,
    output pipePkg::fwdSelT                  fwdB,
    output logic                             dataMemForward
);

    logic readsRt;
    logic memLive;
    logic wbLive;

    // Ops whose B operand is the rt register
    always_comb begin
        case (idExOp)
            pipePkg::opAdd, pipePkg::opSub, pipePkg::opAnd,
            pipePkg::opOr, pipePkg::opSlt, pipePkg::opSll,
            pipePkg::opSw: readsRt = 1'b1;
            default:       readsRt = 1'b0;
        endcase
    end

    // Zero register never forwarded
    // Load result not ready in EX/MEM yet so that path is closed to loads
    assign memLive = exMemRegWrite && !exMemMemRead && (exMemDest != '0);
    assign wbLive  = memWbRegWrite && (memWbDest != '0);

    ////////////////////
    // Operand selects
    ////////////////////

    always_comb begin
        // Newer EX/MEM result wins over MEM/WB
        if (memLive && (exMemDest == idExRs)) begin
            fwdA = pipePkg::fwdMem;
        end else if (wbLive && (memWbDest == idExRs)) begin
            fwdA = pipePkg::fwdWb;
        end else begin
            fwdA = pipePkg::fwdReg;
        end

        if (readsRt && memLive && (exMemDest == idExRt)) begin
            fwdB = pipePkg::fwdMem;
        end else if (readsRt && wbLive && (memWbDest == idExRt)) begin
            fwdB = pipePkg::fwdWb;
        end else begin
            fwdB = pipePkg::fwdReg;
        end
    end

    // Load directly ahead of a store of its target
    // Store picks up wbData one cycle later in MEM
    assign dataMemForward = (idExOp == pipePkg::opSw) && exMemRegWrite
                            && exMemMemRead && (exMemDest != '0)
                            && (exMemDest == idExRt);

endmodule

`default_nettype wire

// ==== exPipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module exPipeline (
    input  logic                              clk,
    input  logic                              rstN,
    // Decoded issue slot
    input  logic                              issueValid,
    input  pipePkg::opcodeT                   issueOp,
    input  logic [pipePkg::regAddrWidth-1:0]  issueRs,
    input  logic [pipePkg::regAddrWidth-1:0]  issueRt,
    input  logic [pipePkg::regAddrWidth-1:0]  issueRd,
    input  logic [pipePkg::immWidth-1:0]      issueImm,
    // Writeback view
    output logic                              wbValid,
    output logic [pipePkg::regAddrWidth-1:0]  wbReg,
    output logic [pipePkg::dataWidth-1:0]     wbData
);

    // Register file read data
    logic [pipePkg::dataWidth-1:0]    rDataA;
    logic [pipePkg::dataWidth-1:0]    rDataB;

    // ID/EX view and forward selects
    pipePkg::opcodeT                  idExOp;
    logic [pipePkg::regAddrWidth-1:0] idExRs;
    logic [pipePkg::regAddrWidth-1:0] idExRt;
    pipePkg::fwdSelT                  fwdA;
    pipePkg::fwdSelT                  fwdB;
    logic                             dataMemForward;

    // EX/MEM
    logic                             exMemValid;
    pipePkg::opcodeT                  exMemOp;
    logic [pipePkg::regAddrWidth-1:0] exMemDest;
    logic                             exMemRegWrite;
    logic                             exMemMemRead;
    logic [pipePkg::dataWidth-1:0]    exMemAlu;
    logic [pipePkg::dataWidth-1:0]    exMemStoreData;
    logic                             exMemStoreFwd;

    // MEM/WB
    logic [pipePkg::regAddrWidth-1:0] memWbDest;
    logic                             memWbRegWrite;

    assign wbReg = memWbDest;

    // Read in the issue cycle, written from MEM/WB
    regFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .rAddrA (issueRs),
        .rAddrB (issueRt),
        .rDataA (rDataA),
        .rDataB (rDataB),
        .we     (memWbRegWrite),
        .wAddr  (memWbDest),
        .wData  (wbData)
    );

    exForwarding uFwd (
        .idExOp         (idExOp),
        .idExRs         (idExRs),
        .idExRt         (idExRt),
        .exMemDest      (exMemDest),
        .exMemRegWrite  (exMemRegWrite),
        .exMemMemRead   (exMemMemRead),
        .memWbDest      (memWbDest),
        .memWbRegWrite  (memWbRegWrite),
        .fwdA           (fwdA),
        .fwdB           (fwdB),
        .dataMemForward (dataMemForward)
    );

    exStage uEx (
        .clk            (clk),
        .rstN           (rstN),
        .issueValid     (issueValid),
        .issueOp        (issueOp),
        .issueRs        (issueRs),
        .issueRt        (issueRt),
        .issueRd        (issueRd),
        .issueImm       (issueImm),
        .rDataA         (rDataA),
        .rDataB         (rDataB),
        .fwdA           (fwdA),
        .fwdB           (fwdB),
        .dataMemForward (dataMemForward),
        .wbData         (wbData),
        .idExOp         (idExOp),
        .idExRs         (idExRs),
        .idExRt         (idExRt),
        .exMemValid     (exMemValid),
        .exMemOp        (exMemOp),
        .exMemDest      (exMemDest),
        .exMemRegWrite  (exMemRegWrite),
        .exMemMemRead   (exMemMemRead),
        .exMemAlu       (exMemAlu),
        .exMemStoreData (exMemStoreData),
        .exMemStoreFwd  (exMemStoreFwd)
    );

    memStage uMem (
        .clk            (clk),
        .rstN           (rstN),
        .exMemValid     (exMemValid),
        .exMemOp        (exMemOp),
        .exMemDest      (exMemDest),
        .exMemRegWrite  (exMemRegWrite),
        .exMemMemRead   (exMemMemRead),
        .exMemAlu       (exMemAlu),
        .exMemStoreData (exMemStoreData),
        .exMemStoreFwd  (exMemStoreFwd),
        .memWbDest      (memWbDest),
        .memWbRegWrite  (memWbRegWrite),
        .wbValid        (wbValid),
        .wbData         (wbData)
    );

endmodule

`default_nettype wire

// ==== exStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exStage (
    input  logic                              clk,
    input  logic                              rstN,
    // Issue slot plus register file data
    input  logic                              issueValid,
    input  pipePkg::opcodeT                   issueOp,
    input  logic [pipePkg::regAddrWidth-1:0]  issueRs,
    input  logic [pipePkg::regAddrWidth-1:0]  issueRt,
    input  logic [pipePkg::regAddrWidth-1:0]  issueRd,
    input  logic [pipePkg::immWidth-1:0]      issueImm,
    input  logic [pipePkg::dataWidth-1:0]     rDataA,
    input  logic [pipePkg::dataWidth-1:0]     rDataB,
    // From forwarding unit
    input  pipePkg::fwdSelT                   fwdA,
    input  pipePkg::fwdSelT                   fwdB,
    input  logic                              dataMemForward,
    // MEM/WB result
    input  logic [pipePkg::dataWidth-1:0]     wbData,
    // ID/EX view for forwarding
    output pipePkg::opcodeT                   idExOp,
    output logic [pipePkg::regAddrWidth-1:0]  idExRs,
    output logic [pipePkg::regAddrWidth-1:0]  idExRt,
    // EX/MEM register
    output logic                              exMemValid,
    output pipePkg::opcodeT                   exMemOp,
    output logic [pipePkg::regAddrWidth-1:0]  exMemDest,
    output logic                              exMemRegWrite,
    output logic                              exMemMemRead,
    output logic [pipePkg::dataWidth-1:0]     exMemAlu,
    output logic [pipePkg::dataWidth-1:0]     exMemStoreData,
    output logic                              exMemStoreFwd
);

    logic                             idExValid;
    logic [pipePkg::regAddrWidth-1:0] idExRd;
    logic [pipePkg::immWidth-1:0]     idExImm;
    logic [pipePkg::dataWidth-1:0]    idExA;
    logic [pipePkg::dataWidth-1:0]    idExB;
    logic [pipePkg::dataWidth-1:0]    opA;
    logic [pipePkg::dataWidth-1:0]    opB;
    logic [pipePkg::dataWidth-1:0]    aluResult;
    logic [pipePkg::regAddrWidth-1:0] exDest;
    logic                             exRegWrite;
    logic                             exMemReadNext;

    ////////////////////
    // ID/EX
    ////////////////////

    // Bubble enters as nop
    always_ff @(posedge clk) begin
        if (!rstN) begin
            idExValid <= 1'b0;
            idExOp    <= pipePkg::opNop;
        end else begin
            idExValid <= issueValid;
            idExOp    <= issueValid ? issueOp : pipePkg::opNop;
        end
    end

    always_ff @(posedge clk) begin
        idExRs  <= issueRs;
        idExRt  <= issueRt;
        idExRd  <= issueRd;
        idExImm <= issueImm;
        idExA   <= rDataA;
        idExB   <= rDataB;
    end

    // Operand muxes
    always_comb begin
        case (fwdA)
            pipePkg::fwdMem: opA = exMemAlu;
            pipePkg::fwdWb:  opA = wbData;
            default:         opA = idExA;
        endcase

        case (fwdB)
            pipePkg::fwdMem: opB = exMemAlu;
            pipePkg::fwdWb:  opB = wbData;
            default:         opB = idExB;
        endcase
    end

    // R-type and shift write rd, addi and load write rt
    always_comb begin
        exDest        = idExRd;
        exRegWrite    = 1'b0;
        exMemReadNext = 1'b0;
        case (idExOp)
            pipePkg::opAdd, pipePkg::opSub, pipePkg::opAnd,
            pipePkg::opOr, pipePkg::opSlt, pipePkg::opSll: begin
                exRegWrite = idExValid;
            end
            pipePkg::opAddi: begin
                exDest     = idExRt;
                exRegWrite = idExValid;
            end
            pipePkg::opLw: begin
                exDest        = idExRt;
                exRegWrite    = idExValid;
                exMemReadNext = idExValid;
            end
            default: exRegWrite = 1'b0;
        endcase
    end

    alu uAlu (
        .op     (idExOp),
        .a      (opA),
        .b      (opB),
        .imm    (idExImm),
        .result (aluResult)
    );

    ////////////////////
    // EX/MEM
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMemValid    <= 1'b0;
            exMemOp       <= pipePkg::opNop;
            exMemRegWrite <= 1'b0;
            exMemMemRead  <= 1'b0;
            exMemStoreFwd <= 1'b0;
        end else begin
            exMemValid    <= idExValid;
            exMemOp       <= idExOp;
            exMemRegWrite <= exRegWrite;
            exMemMemRead  <= exMemReadNext;
            exMemStoreFwd <= dataMemForward && idExValid;
        end
    end

    // Store data is the forwarded rt value
    always_ff @(posedge clk) begin
        exMemDest      <= exDest;
        exMemAlu       <= aluResult;
        exMemStoreData <= opB;
    end

endmodule

`default_nettype wire

// ==== memStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memStage (
    input  logic                              clk,
    input  logic                              rstN,
    // EX/MEM register
    input  logic                              exMemValid,
    input  pipePkg::opcodeT                   exMemOp,
    input  logic [pipePkg::regAddrWidth-1:0]  exMemDest,
    input  logic                              exMemRegWrite,
    input  logic                              exMemMemRead,
    input  logic [pipePkg::dataWidth-1:0]     exMemAlu,
    input  logic [pipePkg::dataWidth-1:0]     exMemStoreData,
    input  logic                              exMemStoreFwd,
    // MEM/WB register, also the register file write port
    output logic [pipePkg::regAddrWidth-1:0]  memWbDest,
    output logic                              memWbRegWrite,
    output logic                              wbValid,
    output logic [pipePkg::dataWidth-1:0]     wbData
);

    logic [pipePkg::dataWidth-1:0]    dataMem [pipePkg::memDepth];
    logic [pipePkg::memAddrWidth-1:0] memAddr;
    logic [pipePkg::dataWidth-1:0]    storeData;
    logic [pipePkg::dataWidth-1:0]    loadData;
    logic                             memWe;

    // Word index from byte address
    assign memAddr = exMemAlu[pipePkg::memAddrWidth+1:2];

    assign memWe = exMemValid && (exMemOp == pipePkg::opSw);

    // Load one ahead now sits in MEM/WB
    // Its data is on wbData this cycle
    assign storeData = exMemStoreFwd ? wbData : exMemStoreData;

    ////////////////////
    // Data memory
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < pipePkg::memDepth; i++) begin
                dataMem[i] <= '0;
            end
        end else if (memWe) begin
            dataMem[memAddr] <= storeData;
        end
    end

    // Async read
    assign loadData = dataMem[memAddr];

    ////////////////////
    // MEM/WB
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memWbRegWrite <= 1'b0;
        end else begin
            memWbRegWrite <= exMemRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        memWbDest <= exMemDest;
        wbData    <= exMemMemRead ? loadData : exMemAlu;
    end

    // One pulse per retiring write
    assign wbValid = memWbRegWrite;

endmodule

`default_nettype wire

// ==== pipePkg.sv ====
`default_nettype none

package pipePkg;

    ////////////////////
    // Widths
    ////////////////////

    // Datapath word
    localparam int dataWidth = 32;

    // Register index and register count
    localparam int regAddrWidth = 5;
    localparam int regCount = 1 << regAddrWidth;

    // Raw immediate field before sign extension
    localparam int immWidth = 16;

    // Data memory words, indexed by ALU bits 7 to 2
    localparam int memDepth = 64;
    localparam int memAddrWidth = $clog2(memDepth);

    ////////////////////
    // Encodings
    ////////////////////

    // Decoded operations as issued by the driver
    typedef enum logic [3:0] {
        opNop,  // also what a bubble turns into
        opAdd,
        opSub,
        opAnd,
        opOr,
        opSlt,  // signed compare
        opSll,  // rt shifted by imm[4:0]
        opAddi,
        opLw,
        opSw
    } opcodeT;

    // Operand source select
    // Same code points as the classic 00/01/10 forward mux
    typedef enum logic [1:0] {
        fwdReg = 2'b00,  // ID/EX register value
        fwdWb  = 2'b01,  // MEM/WB result
        fwdMem = 2'b10   // EX/MEM ALU result
    } fwdSelT;

endpackage

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                              clk,
    input  logic                              rstN,
    // Read side, combinational
    input  logic [pipePkg::regAddrWidth-1:0]  rAddrA,
    input  logic [pipePkg::regAddrWidth-1:0]  rAddrB,
    output logic [pipePkg::dataWidth-1:0]     rDataA,
    output logic [pipePkg::dataWidth-1:0]     rDataB,
    // Write side from writeback
    input  logic                              we,
    input  logic [pipePkg::regAddrWidth-1:0]  wAddr,
    input  logic [pipePkg::dataWidth-1:0]     wData
);

    logic [pipePkg::dataWidth-1:0] regs [pipePkg::regCount];
    logic                          wrLive;

    // Register 0 swallows every write
    assign wrLive = we && (wAddr != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < pipePkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wAddr] <= wData;
        end
    end

    ////////////////////
    // Read with bypass
    ////////////////////

    // Write-before-read so an instruction issued in the writeback cycle
    // already sees the new value
    always_comb begin
        if (rAddrA == '0) begin
            rDataA = '0;
        end else if (wrLive && (wAddr == rAddrA)) begin
            rDataA = wData;
        end else begin
            rDataA = regs[rAddrA];
        end

        if (rAddrB == '0) begin
            rDataB = '0;
        end else if (wrLive && (wAddr == rAddrB)) begin
            rDataB = wData;
        end else begin
            rDataB = regs[rAddrB];
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
pipePkg.sv
regFile.sv
exForwarding.sv
alu.sv
exStage.sv
memStage.sv
exPipeline.sv
tbExPipeline.sv

// ==== tbExPipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbExPipeline;

    logic        clk = 1'b0;
    logic        rstN;
    logic        issueValid;
    pipePkg::opcodeT issueOp;
    logic [4:0]  issueRs;
    logic [4:0]  issueRt;
    logic [4:0]  issueRd;
    logic [15:0] issueImm;
    logic        wbValid;
    logic [4:0]  wbReg;
    logic [31:0] wbData;

    // Stimulus table
    logic            tValid [32];
    pipePkg::opcodeT tOp [32];
    logic [4:0]      tRs [32];
    logic [4:0]      tRt [32];
    logic [4:0]      tRd [32];
    logic [15:0]     tImm [32];
    int              tCount = 0;

    // Reference state
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [64];

    // Expected writebacks, oldest first
    logic [4:0]  expReg [$];
    logic [31:0] expData [$];
    int          expCycle [$];

    logic [4:0]  wantReg;
    logic [31:0] wantData;
    int          wantCycle;
    int          cycleCnt = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    int          timeoutCount = 0;
    int          waitCnt;

    exPipeline uut (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueRs    (issueRs),
        .issueRt    (issueRt),
        .issueRd    (issueRd),
        .issueImm   (issueImm),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // Edge counter shared by driver and checker
    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    function automatic logic [15:0] randImm();
        logic [31:0] r;
        r = $urandom;
        return r[15:0];
    endfunction

    task automatic addEntry(input logic v, input pipePkg::opcodeT op, input logic [4:0] rs,
                            input logic [4:0] rt, input logic [4:0] rd, input logic [15:0] imm);
        tValid[tCount] = v;
        tOp[tCount]    = op;
        tRs[tCount]    = rs;
        tRt[tCount]    = rt;
        tRd[tCount]    = rd;
        tImm[tCount]   = imm;
        tCount++;
    endtask

    ////////////////////
    // Program
    ////////////////////

    task automatic loadTable();
        // Independent addi chain with random data
        addEntry(1'b1, pipePkg::opAddi, 5'd0, 5'd1, 5'd0, randImm());
        addEntry(1'b1, pipePkg::opAddi, 5'd0, 5'd2, 5'd0, randImm());
        addEntry(1'b1, pipePkg::opAddi, 5'd0, 5'd3, 5'd0, randImm());
        // Distance one, two and three dependencies
        addEntry(1'b1, pipePkg::opAdd, 5'd1, 5'd2, 5'd4, 16'd0);
        addEntry(1'b1, pipePkg::opSub, 5'd4, 5'd3, 5'd5, 16'd0);
        addEntry(1'b1, pipePkg::opAnd, 5'd5, 5'd1, 5'd6, 16'd0);
        addEntry(1'b1, pipePkg::opOr, 5'd5, 5'd6, 5'd7, 16'd0);
        addEntry(1'b1, pipePkg::opAdd, 5'd5, 5'd7, 5'd8, 16'd0);
        // r9 in both EX/MEM and MEM/WB, newest must win
        addEntry(1'b1, pipePkg::opAddi, 5'd0, 5'd9, 5'd0, randImm());
        addEntry(1'b1, pipePkg::opAddi, 5'd9, 5'd9, 5'd0, 16'd5);
        addEntry(1'b1, pipePkg::opAdd, 5'd9, 5'd9, 5'd10, 16'd0);
        // Write to r0 then read it back as zero
        addEntry(1'b1, pipePkg::opAddi, 5'd0, 5'd0, 5'd0, 16'd123);
        addEntry(1'b1, pipePkg::opAdd, 5'd0, 5'd10, 5'd11, 16'd0);
        // Store, load, bubble, use
        addEntry(1'b1, pipePkg::opAddi, 5'd0, 5'd12, 5'd0, 16'd64);
        addEntry(1'b1, pipePkg::opSw, 5'd12, 5'd10, 5'd0, 16'd4);
        addEntry(1'b1, pipePkg::opLw, 5'd12, 5'd13, 5'd0, 16'd4);
        addEntry(1'b0, pipePkg::opAddi, 5'd0, 5'd14, 5'd0, 16'd77);
        addEntry(1'b1, pipePkg::opAdd, 5'd13, 5'd1, 5'd14, 16'd0);
        // Load then store of the loaded register, no bubble
        addEntry(1'b1, pipePkg::opLw, 5'd12, 5'd15, 5'd0, 16'd4);
        addEntry(1'b1, pipePkg::opSw, 5'd12, 5'd15, 5'd0, 16'd8);
        addEntry(1'b1, pipePkg::opLw, 5'd12, 5'd16, 5'd0, 16'd8);
        // Negative operand for shift and compare
        addEntry(1'b1, pipePkg::opAddi, 5'd0, 5'd17, 5'd0, randImm() | 16'h8000);
        // r12 holds 64 so signed and unsigned order disagree
        addEntry(1'b1, pipePkg::opSlt, 5'd17, 5'd12, 5'd18, 16'd0);
        addEntry(1'b1, pipePkg::opSlt, 5'd12, 5'd17, 5'd19, 16'd0);
        addEntry(1'b1, pipePkg::opSll, 5'd0, 5'd17, 5'd20, 16'd7);
        addEntry(1'b1, pipePkg::opSll, 5'd0, 5'd17, 5'd21, randImm());
        addEntry(1'b1, pipePkg::opSub, 5'd0, 5'd17, 5'd22, 16'd0);
        // Issued nop, no writeback
        addEntry(1'b1, pipePkg::opNop, 5'd1, 5'd2, 5'd23, 16'd0);
    endtask

    // Sequential execution of one entry
    // Due cycle is four counter steps past the driving edge
    task automatic modelIssue(input int idx, input int issueCycle);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immExt;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0]  dest;
        logic        writes;
        a      = modelRegs[tRs[idx]];
        b      = modelRegs[tRt[idx]];
        immExt = {{16{tImm[idx][15]}}, tImm[idx]};
        addr   = a + immExt;
        res    = '0;
        dest   = tRd[idx];
        writes = 1'b0;
        if (tValid[idx]) begin
            writes = 1'b1;
            case (tOp[idx])
                pipePkg::opAdd: res = a + b;
                pipePkg::opSub: res = a - b;
                pipePkg::opAnd: res = a & b;
                pipePkg::opOr:  res = a | b;
                pipePkg::opSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                pipePkg::opSll: res = b << tImm[idx][4:0];
                pipePkg::opAddi: begin
                    res  = addr;
                    dest = tRt[idx];
                end
                pipePkg::opLw: begin
                    res  = modelMem[addr[7:2]];
                    dest = tRt[idx];
                end
                pipePkg::opSw: begin
                    modelMem[addr[7:2]] = b;
                    writes = 1'b0;
                end
                default: writes = 1'b0;
            endcase
        end
        if (writes) begin
            // r0 still shows on the writeback port
            if (dest != 5'd0) begin
                modelRegs[dest] = res;
            end
            expReg.push_back(dest);
            expData.push_back(res);
            expCycle.push_back(issueCycle + 4);
        end
    endtask

    ////////////////////
    // Checker
    ////////////////////

    // Mid-cycle sample, away from the driving edge
    always @(negedge clk) begin
        if (!rstN) begin
            if (wbValid === 1'b1) begin
                errorCount++;
                $display("Writeback strobe seen during reset at %0t", $time);
            end
        end else if (wbValid === 1'b1) begin
            if (expReg.size() == 0) begin
                errorCount++;
                $display("Unexpected writeback of register %0d at %0t", wbReg, $time);
            end else begin
                wantReg   = expReg.pop_front();
                wantData  = expData.pop_front();
                wantCycle = expCycle.pop_front();
                checkCount++;
                if (cycleCnt != wantCycle) begin
                    errorCount++;
                    $display("FAIL %0t wbValid cycle got %0d expected %0d",
                             $time, cycleCnt, wantCycle);
                end
                if (wbReg != wantReg) begin
                    errorCount++;
                    $display("FAIL %0t wbReg got %0d expected %0d", $time, wbReg, wantReg);
                end
                if (wbData != wantData) begin
                    errorCount++;
                    $display("FAIL %0t wbData got %h expected %h", $time, wbData, wantData);
                end
            end
        end
    end

    ////////////////////
    // Driver
    ////////////////////

    initial begin
        rstN       = 1'b0;
        issueValid = 1'b0;
        issueOp    = pipePkg::opNop;
        issueRs    = '0;
        issueRt    = '0;
        issueRd    = '0;
        issueImm   = '0;
        void'($urandom(86595));
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            modelMem[i] = '0;
        end
        loadTable();

        // Four reset edges
        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        // One entry per cycle
        for (int i = 0; i < tCount; i++) begin
            @(posedge clk);
            issueValid <= tValid[i];
            issueOp    <= tOp[i];
            issueRs    <= tRs[i];
            issueRt    <= tRt[i];
            issueRd    <= tRd[i];
            issueImm   <= tImm[i];
            modelIssue(i, cycleCnt);
        end
        @(posedge clk);
        issueValid <= 1'b0;
        issueOp    <= pipePkg::opNop;

        // Drain with timeout
        for (waitCnt = 0; waitCnt < 20 && expReg.size() != 0; waitCnt++) begin
            @(posedge clk);
        end
        if (expReg.size() != 0) begin
            timeoutCount++;
            $display("Timed out, %0d expected writebacks did not appear", expReg.size());
        end

        // Quiet window for stray strobes
        repeat (4) @(posedge clk);

        $display("Checked %0d writebacks, %0d errors, %0d timeouts",
                 checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
